// ==== build.f ====
verilog/irq_cfg_pkg.sv
verilog/irq_types_pkg.sv
verilog/prio_result_if.sv
verilog/irq_capture.sv
verilog/priority_comp.sv
verilog/irq_dispatch.sv
verilog/irq_resolver_top.sv
tests/irq_resolver_sva.sv
tests/irq_resolver_tb.sv

// ==== tests/irq_resolver_tb.sv ====
// ======================================
// testbench for the interrupt resolver
// reference model, compare process, directed and random tests
// ======================================
`timescale 1ns/100ps

module irq_resolver_tb;
    import irq_cfg_pkg::*;

    localparam int CLK_HALF    = 20;
    localparam int RST_CYC     = 10;
    localparam logic [15:0] SEED = 16'd3384;

    // rough cycle budget per test
    localparam int LEN_T1      = 20;
    localparam int LEN_T2      = 160;
    localparam int LEN_T3      = 80;
    localparam int LEN_T4      = 50;
    localparam int LEN_T5      = 60;
    localparam int LEN_T6      = 330;
    localparam int MARGIN      = 200;
    localparam int TIMEOUT_CYC = RST_CYC + LEN_T1 + LEN_T2 + LEN_T3 + LEN_T4 + LEN_T5
                                 + LEN_T6 + MARGIN;
    localparam int RAND_CYC    = 200;
    localparam int DRAIN_MAX   = 200;

    logic               clk;
    logic               rst_n;
    logic [NUM_SRC-1:0] req;
    logic [NUM_SRC-1:0] edge_sel;
    logic [NUM_SRC-1:0] mask;
    logic               ack;
    logic               irq;
    logic [IDX_W-1:0]   vector;
    logic               fault;

    // model state
    logic [NUM_SRC-1:0] m_pending;
    logic [NUM_SRC-1:0] m_req_q;
    logic [NUM_SRC-1:0] hist [0:3];
    logic [IDX_W-1:0]   exp_vector;
    logic               irq_seen;
    logic               fault_seen;
    int                 exp_idx;

    logic [15:0]        lfsr_state;
    int                 error_count;
    int                 check_count;
    int                 serve_count;
    int                 tests_run;
    int                 cycle_count;

    irq_resolver_top u_irq_resolver_top (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (req),
        .edge_sel (edge_sel),
        .mask     (mask),
        .ack      (ack),
        .irq      (irq),
        .vector   (vector),
        .fault    (fault)
    );

    bind irq_dispatch irq_resolver_sva u_irq_resolver_sva (
        .clk   (clk),
        .rst_n (rst_n),
        .ack   (ack),
        .irq   (irq),
        .clr   (clr),
        .fault (fault),
        .state (state)
    );

    always #(CLK_HALF) clk = ~clk;

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    function automatic logic [7:0] take_bits(input int n);
        logic [7:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v          = {v[6:0], lfsr_state[15]};
            lfsr_state = lfsr_step(lfsr_state);
        end
        return v;
    endfunction

    // highest index wins, -1 when nothing is active
    function automatic int highest_set(input logic [NUM_SRC-1:0] bits);
        for (int i = NUM_SRC - 1; i >= 0; i--) begin
            if (bits[i]) begin
                return i;
            end
        end
        return -1;
    endfunction

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("** Error at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    // pending set per the capture rules, sampled at the rising edge
    always @(posedge clk) begin
        if (!rst_n) begin
            m_pending = '0;
            m_req_q   = '0;
            for (int k = 0; k < 4; k++) begin
                hist[k] = '0;
            end
        end else begin
            // comparator input is the active set from before this edge
            hist[3] = hist[2];
            hist[2] = hist[1];
            hist[1] = hist[0];
            hist[0] = m_pending & mask;
            for (int i = 0; i < NUM_SRC; i++) begin
                if (irq_seen && ack && (exp_vector == i)) begin
                    m_pending[i] = 1'b0;
                end else if (edge_sel[i]) begin
                    m_pending[i] = m_pending[i] | (req[i] & ~m_req_q[i]);
                end else begin
                    m_pending[i] = req[i];
                end
            end
            m_req_q = req;
        end
    end

    // compare each new irq with the model
    always @(negedge clk) begin
        if (!rst_n) begin
            irq_seen   = 1'b0;
            fault_seen = 1'b0;
        end else begin
            if (irq && !irq_seen) begin
                serve_count++;
                exp_idx = highest_set(hist[3]);
                if (exp_idx < 0) begin
                    error_count++;
                    $display("irq raised at %0t ns with no active request", $time);
                end else begin
                    check("vector", vector, exp_idx);
                    exp_vector = IDX_W'(exp_idx);
                end
            end
            if (fault && !fault_seen) begin
                fault_seen = 1'b1;
                check("fault", fault, 0);
            end
            irq_seen = irq;
        end
    end

    task automatic wait_irq(input int limit, output int cycles);
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!irq && cycles < limit);
        if (!irq) begin
            error_count++;
            $display("no irq within %0d cycles at %0t ns", limit, $time);
        end
    endtask

    task automatic ack_irq();
        ack = 1'b1;
        @(negedge clk);
        ack = 1'b0;
    endtask

    task automatic expect_quiet(input int n);
        repeat (n) begin
            @(negedge clk);
            check("irq while quiet", irq, 0);
        end
    endtask

    task automatic finish_test(input string name, input int errs_before);
        @(negedge clk);
        tests_run++;
        $display("test %-24s done, %0d errors", name, error_count - errs_before);
    endtask

    initial begin : watchdog
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYC) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("run hung: no end after %0d cycles", TIMEOUT_CYC);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        int                 cyc;
        int                 errs;
        int                 quiet;
        int                 ack_delay;
        int                 serves_before;
        logic [NUM_SRC-1:0] pat;

        clk         = 1'b0;
        rst_n       = 1'b0;
        req         = '0;
        edge_sel    = '1;
        mask        = '1;
        ack         = 1'b0;
        lfsr_state  = SEED;
        exp_vector  = '0;
        error_count = 0;
        check_count = 0;
        serve_count = 0;
        tests_run   = 0;
        repeat (RST_CYC) @(negedge clk);
        rst_n = 1'b1;

        // 1: idle after reset
        errs = error_count;
        repeat (LEN_T1) begin
            @(negedge clk);
            check("irq after reset", irq, 0);
            check("fault after reset", fault, 0);
            check("vector after reset", vector, 0);
        end
        finish_test("reset idle", errs);

        // 2: single edge source, fixed latency
        errs = error_count;
        for (int i = 0; i < NUM_SRC; i++) begin
            @(negedge clk);
            req = NUM_SRC'(1) << i;
            wait_irq(10, cyc);
            check("irq latency", cyc, 5);
            check("single vector", vector, i);
            ack_irq();
            req = '0;
            expect_quiet(12);
        end
        finish_test("single edge sources", errs);

        // 3: several pending, served from the top down
        errs = error_count;
        pat  = 8'hB5;
        @(negedge clk);
        req = pat;
        @(negedge clk);
        req = '0;
        for (int b = NUM_SRC - 1; b >= 0; b--) begin
            if (pat[b]) begin
                wait_irq(20, cyc);
                check("descending vector", vector, b);
                ack_irq();
            end
        end
        expect_quiet(20);
        finish_test("descending order", errs);

        // 4: masked source kept pending
        errs = error_count;
        @(negedge clk);
        mask = 8'hBF;
        req  = 8'h40;
        @(negedge clk);
        req = '0;
        expect_quiet(20);
        mask = '1;
        wait_irq(10, cyc);
        check("unmasked vector", vector, 6);
        ack_irq();
        expect_quiet(12);
        finish_test("mask hold", errs);

        // 5: level source re-served until it drops
        errs = error_count;
        @(negedge clk);
        edge_sel = 8'hF7;
        req      = 8'h08;
        for (int k = 0; k < 3; k++) begin
            wait_irq(20, cyc);
            check("level vector", vector, 3);
            if (k == 2) begin
                req = '0;
            end
            ack_irq();
        end
        expect_quiet(20);
        edge_sel = '1;
        finish_test("level source", errs);

        // 6: random requests, masks and ack delays
        errs          = error_count;
        serves_before = serve_count;
        ack_delay     = -1;
        edge_sel      = 8'hCC;
        for (int c = 0; c < RAND_CYC; c++) begin
            @(negedge clk);
            req = take_bits(8) & take_bits(8);
            if (c % 25 == 0) begin
                mask = take_bits(8);
            end
            ack = 1'b0;
            if (irq) begin
                if (ack_delay < 0) begin
                    ack_delay = take_bits(2);
                end
                if (ack_delay == 0) begin
                    ack       = 1'b1;
                    ack_delay = -1;
                end else begin
                    ack_delay--;
                end
            end
        end
        // serve whatever is left
        req   = '0;
        mask  = '1;
        quiet = 0;
        for (int c = 0; c < DRAIN_MAX && quiet < 20; c++) begin
            @(negedge clk);
            if (irq) begin
                ack   = 1'b1;
                quiet = 0;
            end else begin
                ack = 1'b0;
                quiet++;
            end
        end
        ack = 1'b0;
        if (quiet < 20) begin
            error_count++;
            $display("random test did not drain within %0d cycles", DRAIN_MAX);
        end
        check("fault after random", fault, 0);
        check("random serves seen", serve_count > serves_before, 1);
        finish_test("random traffic", errs);

        $display("%0d tests, %0d checks, %0d irqs served, %0d errors",
                 tests_run, check_count, serve_count, error_count);
        if (error_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// ==== tests/irq_resolver_sva.sv ====
// ======================================
// dispatcher protocol assertions
// ======================================
`timescale 1ns/100ps

module irq_resolver_sva (
    input logic                        clk,
    input logic                        rst_n,
    input logic                        ack,
    input logic                        irq,
    input logic                        clr,
    input logic                        fault,
    input irq_types_pkg::disp_state_e  state
);
    import irq_types_pkg::*;

    // irq is a level held until the processor acks
    irq_held: assert property (@(posedge clk) disable iff (!rst_n)
        irq && !ack |=> irq)
        else $error("irq dropped without an ack");

    // clear strobe only on an ack of a raised irq
    clr_on_ack: assert property (@(posedge clk) disable iff (!rst_n)
        clr |-> ack && irq)
        else $error("clr pulsed outside an accepted ack");

    ack_clears: assert property (@(posedge clk) disable iff (!rst_n)
        irq && ack |-> clr)
        else $error("accepted ack gave no clr");

    // one-cycle strobe, irq gone at the next edge
    clr_single: assert property (@(posedge clk) disable iff (!rst_n)
        clr |=> !clr && !irq)
        else $error("clr held or irq kept after the clear");

    // stale pipeline results must not be served
    no_irq_in_holdoff: assert property (@(posedge clk) disable iff (!rst_n)
        state == DISP_HOLDOFF |=> !irq)
        else $error("irq raised during holdoff");

    // sticky fault
    fault_sticky: assert property (@(posedge clk) disable iff (!rst_n)
        fault |=> fault)
        else $error("fault fell after being set");

endmodule

// ==== verilog/irq_resolver_top.sv ====
// ======================================
// interrupt resolver top level
// ======================================
`timescale 1ns/100ps

module irq_resolver_top (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic [irq_cfg_pkg::NUM_SRC-1:0]  req,
    input  logic [irq_cfg_pkg::NUM_SRC-1:0]  edge_sel,
    input  logic [irq_cfg_pkg::NUM_SRC-1:0]  mask,
    input  logic                             ack,
    output logic                             irq,
    output logic [irq_cfg_pkg::IDX_W-1:0]    vector,
    output logic                             fault
);
    import irq_cfg_pkg::*;

    logic [NUM_SRC-1:0] active;
    logic               clr;
    logic [IDX_W-1:0]   clr_index;

    prio_result_if res_if ();

    irq_capture u_irq_capture (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req),
        .edge_sel  (edge_sel),
        .mask      (mask),
        .clr       (clr),
        .clr_index (clr_index),
        .active    (active)
    );

    // fixed latency of PIPE_DEPTH
    priority_comp u_priority_comp (
        .clk     (clk),
        .rst_n   (rst_n),
        .data_in (active),
        .res     (res_if.comp)
    );

    irq_dispatch u_irq_dispatch (
        .clk       (clk),
        .rst_n     (rst_n),
        .res       (res_if.disp),
        .ack       (ack),
        .irq       (irq),
        .vector    (vector),
        .fault     (fault),
        .clr       (clr),
        .clr_index (clr_index)
    );

endmodule

// ==== verilog/irq_dispatch.sv ====
// ======================================
// irq/ack dispatcher with post-ack holdoff
// ======================================
`timescale 1ns/100ps

module irq_dispatch (
    input  logic                           clk,
    input  logic                           rst_n,
    prio_result_if.disp                    res,
    input  logic                           ack,
    output logic                           irq,
    output logic [irq_cfg_pkg::IDX_W-1:0]  vector,
    output logic                           fault,
    output logic                           clr,
    output logic [irq_cfg_pkg::IDX_W-1:0]  clr_index
);
    import irq_cfg_pkg::*;
    import irq_types_pkg::*;

    disp_state_e       state;
    served_t           served;
    logic [HOLD_W-1:0] hold_cnt;
    logic              hit;
    logic              take;

    // index and one-hot have to agree
    assign hit  = res.onehot[res.index];
    assign take = res.valid && !res.error && hit;

    // accepted ack clears the served source
    assign clr       = (state == DISP_WAIT_ACK) && ack;
    assign clr_index = served.index;

    assign irq    = served.busy;
    assign vector = served.index;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= DISP_IDLE;
            served   <= '0;
            hold_cnt <= '0;
        end else begin
            case (state)
                DISP_IDLE: begin
                    if (take) begin
                        served.index <= res.index;
                        served.busy  <= 1'b1;
                        state        <= DISP_WAIT_ACK;
                    end
                end
                DISP_WAIT_ACK: begin
                    if (ack) begin
                        served.busy <= 1'b0;
                        hold_cnt    <= HOLD_W'(HOLDOFF_CYC - 1);
                        state       <= DISP_HOLDOFF;
                    end
                end
                DISP_HOLDOFF: begin
                    // results in flight still show the cleared source
                    if (hold_cnt == '0) begin
                        state <= DISP_IDLE;
                    end else begin
                        hold_cnt <= hold_cnt - 1'b1;
                    end
                end
                default: begin
                    state <= DISP_IDLE;
                end
            endcase
        end
    end

    // sticky, watched in every state
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fault <= 1'b0;
        end else if (res.valid && (res.error || !hit)) begin
            fault <= 1'b1;
        end
    end

endmodule

// ==== verilog/priority_comp.sv ====
// ======================================
// three-stage priority encoder with self-check
// ======================================
`timescale 1ns/100ps

module priority_comp (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic [irq_cfg_pkg::NUM_SRC-1:0]  data_in,
    prio_result_if.comp                      res
);
    import irq_cfg_pkg::*;

    // stage 1
    logic [NUM_SRC-1:0] data1;
    logic               any1;

    // stage 2
    logic [NUM_SRC-1:0] data2;
    logic [IDX_W-1:0]   idx2;
    logic [NUM_SRC-1:0] onehot2;
    logic               any2;

    logic [IDX_W-1:0]   idx1;

    // highest set bit, 0 when empty
    function automatic logic [IDX_W-1:0] find_high(input logic [NUM_SRC-1:0] data);
        logic [IDX_W-1:0] result;
        result = '0;
        for (int i = 0; i < NUM_SRC; i++) begin
            if (data[i]) begin
                result = IDX_W'(i);
            end
        end
        return result;
    endfunction

    assign idx1 = find_high(data1);

    // control chain
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            any1      <= 1'b0;
            any2      <= 1'b0;
            res.valid <= 1'b0;
            res.error <= 1'b0;
        end else begin
            any1      <= |data_in;
            any2      <= any1;
            res.valid <= any2;
            // chosen bit must be set in the same item's data
            res.error <= any2 && ((data2 & onehot2) == '0);
        end
    end

    // payload chain
    always_ff @(posedge clk) begin
        data1      <= data_in;
        data2      <= data1;
        idx2       <= idx1;
        onehot2    <= any1 ? (NUM_SRC'(1) << idx1) : '0;
        res.index  <= idx2;
        res.onehot <= onehot2;
    end

endmodule

// ==== verilog/irq_capture.sv ====
// ======================================
// request capture, pending register and mask
// ======================================
`timescale 1ns/100ps

module irq_capture (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [irq_cfg_pkg::NUM_SRC-1:0]   req,
    input  logic [irq_cfg_pkg::NUM_SRC-1:0]   edge_sel,
    input  logic [irq_cfg_pkg::NUM_SRC-1:0]   mask,
    input  logic                              clr,
    input  logic [irq_cfg_pkg::IDX_W-1:0]     clr_index,
    output logic [irq_cfg_pkg::NUM_SRC-1:0]   active
);
    import irq_cfg_pkg::*;

    logic [NUM_SRC-1:0] req_q;
    logic [NUM_SRC-1:0] pending;
    logic [NUM_SRC-1:0] rise;
    logic [NUM_SRC-1:0] clr_vec;
    logic [NUM_SRC-1:0] pend_nxt;

    // rising edges seen between two samples
    assign rise = req & ~req_q;

    // decode the served source being cleared
    always_comb begin
        clr_vec = '0;
        if (clr) begin
            clr_vec[clr_index] = 1'b1;
        end
    end

    // edge sources accumulate, level sources track req
    // clear wins over a set in the same cycle
    always_comb begin
        pend_nxt = ((edge_sel & (pending | rise)) | (~edge_sel & req)) & ~clr_vec;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req_q   <= '0;
            pending <= '0;
        end else begin
            req_q   <= req;
            pending <= pend_nxt;
        end
    end

    // masked bits stay pending, just hidden
    assign active = pending & mask;

endmodule

// ==== verilog/prio_result_if.sv ====
// ======================================
// comparator result bundle
// ======================================
`timescale 1ns/100ps

interface prio_result_if;
    import irq_cfg_pkg::*;

    // winning source and its one-hot mask
    logic [IDX_W-1:0]   index;
    logic [NUM_SRC-1:0] onehot;

    // any gated request present three cycles earlier
    logic               valid;

    // self-check failure on this item
    logic               error;

    modport comp (
        output index, onehot, valid, error
    );

    modport disp (
        input index, onehot, valid, error
    );

endinterface

// ==== verilog/irq_types_pkg.sv ====
// ======================================
// dispatcher state and served-source record
// ======================================

package irq_types_pkg;

    // dispatcher FSM
    typedef enum logic [1:0] {
        DISP_IDLE     = 2'd0,
        DISP_WAIT_ACK = 2'd1,
        DISP_HOLDOFF  = 2'd2
    } disp_state_e;

    // source currently presented to the processor
    typedef struct packed {
        logic [irq_cfg_pkg::IDX_W-1:0] index;
        logic                          busy;
    } served_t;

endpackage

// ==== verilog/irq_cfg_pkg.sv ====
// ======================================
// sizing constants for the interrupt resolver
// ======================================

package irq_cfg_pkg;

    // interrupt sources, highest index wins
    localparam int NUM_SRC = 8;

    // width of a source index
    localparam int IDX_W = $clog2(NUM_SRC);

    // register stages in the priority comparator
    localparam int PIPE_DEPTH = 3;

    // cycles held off after an ack
    // the capture update plus a full pipeline flush
    localparam int HOLDOFF_CYC = PIPE_DEPTH + 1;

    // holdoff down-counter width
    localparam int HOLD_W = $clog2(HOLDOFF_CYC);

endpackage
